// File: source/bossPkg.sv
package bossPkg;

    typedef logic signed [10:0] coord_t;
    typedef logic [7:0] color_t;
    typedef logic [6:0] collision_t;
    typedef logic signed [3:0] step_t;
    typedef logic [6:0] cooldown_t;
    typedef logic [3:0] deathCount_t;
    typedef logic [7:0] maskRow_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } position_t;

    typedef struct packed {
        logic      active;
        position_t pos;
        step_t     stepX;
    } missileSlot_t;

    localparam int missileCount = 5;

    typedef missileSlot_t [missileCount-1:0] missileArray_t;

    localparam coord_t screenWidth = 11'sd640;
    localparam coord_t screenHeight = 11'sd480;
    localparam coord_t bossSize = 11'sd64;
    localparam coord_t initialX = 11'sd300;
    localparam coord_t initialY = 11'sd200;
    localparam coord_t bossStepX = 11'sd2;
    localparam coord_t bossStepY = 11'sd1;
    localparam coord_t bossMinX = 11'sd0;
    localparam coord_t bossMaxX = screenWidth - bossSize;
    localparam coord_t bossMinY = 11'sd0;
    localparam coord_t bossMaxY = 11'sd240;

    localparam coord_t missileSize = 11'sd4;
    localparam coord_t missileStepY = 11'sd2;
    localparam coord_t missileOffsetX = 11'sd30;
    localparam coord_t missileOffsetY = 11'sd60;
    localparam cooldown_t cooldownFrames = 7'd90;
    localparam deathCount_t deathFrames = 4'd10;

    // Row 0 is the top of the sprite, bit 7 the leftmost 8x8 block.
    localparam maskRow_t [0:7] bossMask = '{
        8'b00011000,
        8'b00111100,
        8'b01111110,
        8'b11011011,
        8'b11111111,
        8'b00100100,
        8'b01011010,
        8'b10100101
    };

    localparam color_t bossColor = 8'hE4;
    localparam color_t missileColor = 8'hD0;

    // Slot 2 of the fan falls straight down.
    function automatic step_t spawnStep(input int slot);
        return step_t'(slot - 2);
    endfunction

endpackage

// File: source/bossMotion.sv
module bossMotion (
    input  logic                clk,
    input  logic                reset,
    input  logic                frameTick,
    input  logic                bossPixelHit,
    input  bossPkg::collision_t collision,
    output bossPkg::position_t  bossPos,
    output logic                bossAlive,
    output logic                bossVisible
);

    logic movingRight;
    logic movingDown;
    logic hitLatched;
    logic hitNow;
    logic flipX;
    logic flipY;
    bossPkg::deathCount_t deathCount;
    bossPkg::coord_t stepX;
    bossPkg::coord_t stepY;
    bossPkg::coord_t rawX;
    bossPkg::coord_t rawY;
    bossPkg::position_t nextPos;

    assign hitNow = collision[0] && bossPixelHit; // Player shot on a boss pixel.
    assign bossAlive = !hitLatched && !hitNow;

    always_comb begin
        stepX = movingRight ? bossPkg::bossStepX : -bossPkg::bossStepX;
        stepY = movingDown ? bossPkg::bossStepY : -bossPkg::bossStepY;
        rawX = bossPos.x + stepX;
        rawY = bossPos.y + stepY;
        nextPos.x = rawX;
        nextPos.y = rawY;
        flipX = 1'b0;
        flipY = 1'b0;
        if (rawX > bossPkg::bossMaxX) begin
            nextPos.x = bossPkg::bossMaxX;
            flipX = 1'b1;
        end else if (rawX < bossPkg::bossMinX) begin
            nextPos.x = bossPkg::bossMinX;
            flipX = 1'b1;
        end
        if (rawY > bossPkg::bossMaxY) begin
            nextPos.y = bossPkg::bossMaxY;
            flipY = 1'b1;
        end else if (rawY < bossPkg::bossMinY) begin
            nextPos.y = bossPkg::bossMinY;
            flipY = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bossPos <= '{x: bossPkg::initialX, y: bossPkg::initialY};
            movingRight <= 1'b1;
            movingDown <= 1'b1;
        end else if (frameTick) begin
            bossPos <= nextPos;
            movingRight <= movingRight ^ flipX; // Bounce off the bound.
            movingDown <= movingDown ^ flipY;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hitLatched <= 1'b0;
            deathCount <= '0;
            bossVisible <= 1'b1;
        end else begin
            if (hitNow) begin
                hitLatched <= 1'b1;
            end
            // Ticks in the hit cycle itself do not count.
            if (frameTick && hitLatched && bossVisible) begin
                if (deathCount == bossPkg::deathFrames - 1) begin
                    bossVisible <= 1'b0;
                end
                deathCount <= deathCount + 1'b1;
            end
        end
    end

endmodule

// File: source/missilePool.sv
module missilePool (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          frameTick,
    input  logic                          bossAlive,
    input  bossPkg::position_t            bossPos,
    input  logic [bossPkg::missileCount-1:0] missilePixelHit,
    input  bossPkg::collision_t           collision,
    output bossPkg::missileArray_t        missiles
);

    bossPkg::cooldown_t cooldown;
    logic movePhase;
    logic fire;
    logic advance;
    logic strikeFlag;
    logic [bossPkg::missileCount-1:0] slotActive;
    logic [bossPkg::missileCount-1:0] struck;
    bossPkg::position_t [bossPkg::missileCount-1:0] slotPos;
    bossPkg::position_t [bossPkg::missileCount-1:0] nextPos;
    bossPkg::step_t [bossPkg::missileCount-1:0] slotStep;
    bossPkg::position_t spawnPos;

    assign strikeFlag = collision[2] || collision[4]; // Player or shield contact.
    assign struck = missilePixelHit & {bossPkg::missileCount{strikeFlag}};
    assign fire = frameTick && bossAlive && (cooldown == bossPkg::cooldownFrames - 1);
    assign advance = frameTick && movePhase; // Missiles move on every other tick.

    assign spawnPos.x = bossPos.x + bossPkg::missileOffsetX;
    assign spawnPos.y = bossPos.y + bossPkg::missileOffsetY;

    always_comb begin
        for (int i = 0; i < bossPkg::missileCount; i++) begin
            nextPos[i].x = slotPos[i].x + bossPkg::coord_t'(slotStep[i]);
            nextPos[i].y = slotPos[i].y + bossPkg::missileStepY;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cooldown <= '0;
            movePhase <= 1'b0;
            slotActive <= '0;
        end else begin
            if (frameTick) begin
                movePhase <= !movePhase;
                if (bossAlive) begin
                    cooldown <= fire ? '0 : cooldown + 1'b1;
                end
            end
            for (int i = 0; i < bossPkg::missileCount; i++) begin
                if (fire) begin
                    slotActive[i] <= 1'b1; // A volley reclaims every slot.
                end else if (struck[i]) begin
                    slotActive[i] <= 1'b0;
                end else if (advance && slotActive[i]) begin
                    slotActive[i] <= (nextPos[i].y < bossPkg::screenHeight);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < bossPkg::missileCount; i++) begin
            if (fire) begin
                slotPos[i] <= spawnPos;
                slotStep[i] <= bossPkg::spawnStep(i);
            end else if (advance && slotActive[i]) begin
                slotPos[i] <= nextPos[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < bossPkg::missileCount; i++) begin
            missiles[i].active = slotActive[i];
            missiles[i].pos = slotPos[i];
            missiles[i].stepX = slotStep[i];
        end
    end

endmodule

// File: source/bossRenderer.sv
module bossRenderer (
    input  logic                             clk,
    input  logic                             reset,
    input  bossPkg::coord_t                  pixelX,
    input  bossPkg::coord_t                  pixelY,
    input  bossPkg::position_t               bossPos,
    input  logic                             bossVisible,
    input  bossPkg::missileArray_t           missiles,
    output logic                             bossDrawReq,
    output bossPkg::color_t                  bossRGB,
    output logic                             missileDrawReq,
    output bossPkg::color_t                  missileRGB,
    output logic                             bossPixelHit,
    output logic [bossPkg::missileCount-1:0] missilePixelHit
);

    bossPkg::coord_t bossOffX;
    bossPkg::coord_t bossOffY;
    logic insideBox;
    logic maskBit;
    logic bossHit;
    bossPkg::coord_t [bossPkg::missileCount-1:0] missileOffX;
    bossPkg::coord_t [bossPkg::missileCount-1:0] missileOffY;
    logic [bossPkg::missileCount-1:0] slotHit;

    always_comb begin
        bossOffX = pixelX - bossPos.x;
        bossOffY = pixelY - bossPos.y;
        insideBox = (bossOffX >= 0) && (bossOffX < bossPkg::bossSize)
                 && (bossOffY >= 0) && (bossOffY < bossPkg::bossSize);
        // One mask bit per 8x8 block.
        maskBit = bossPkg::bossMask[bossOffY[5:3]][3'd7 - bossOffX[5:3]];
        bossHit = insideBox && maskBit;
    end

    always_comb begin
        for (int i = 0; i < bossPkg::missileCount; i++) begin
            missileOffX[i] = pixelX - missiles[i].pos.x;
            missileOffY[i] = pixelY - missiles[i].pos.y;
            slotHit[i] = missiles[i].active
                      && (missileOffX[i] >= 0) && (missileOffX[i] < bossPkg::missileSize)
                      && (missileOffY[i] >= 0) && (missileOffY[i] < bossPkg::missileSize);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bossDrawReq <= 1'b0;
            bossPixelHit <= 1'b0;
            missileDrawReq <= 1'b0;
            missilePixelHit <= '0;
        end else begin
            bossDrawReq <= bossHit && bossVisible;
            bossPixelHit <= bossHit; // Hit box stays live while dying.
            missileDrawReq <= |slotHit;
            missilePixelHit <= slotHit;
        end
    end

    assign bossRGB = bossDrawReq ? bossPkg::bossColor : '0;
    assign missileRGB = missileDrawReq ? bossPkg::missileColor : '0;

endmodule

// File: source/bossObject.sv
module bossObject (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic                startOfFrame,
    input  bossPkg::coord_t     pixelX,
    input  bossPkg::coord_t     pixelY,
    input  bossPkg::collision_t collision,
    output logic                bossDrawReq,
    output bossPkg::color_t     bossRGB,
    output logic                missileDrawReq,
    output bossPkg::color_t     missileRGB
);

    logic frameTick;
    logic bossAlive;
    logic bossVisible;
    logic bossPixelHit;
    logic [bossPkg::missileCount-1:0] missilePixelHit;
    bossPkg::position_t bossPos;
    bossPkg::missileArray_t missiles;

    assign frameTick = startOfFrame && enable; // Frame updates only while enabled.

    bossMotion motion (
        .clk          (clk),
        .reset        (reset),
        .frameTick    (frameTick),
        .bossPixelHit (bossPixelHit),
        .collision    (collision),
        .bossPos      (bossPos),
        .bossAlive    (bossAlive),
        .bossVisible  (bossVisible)
    );

    missilePool pool (
        .clk             (clk),
        .reset           (reset),
        .frameTick       (frameTick),
        .bossAlive       (bossAlive),
        .bossPos         (bossPos),
        .missilePixelHit (missilePixelHit),
        .collision       (collision),
        .missiles        (missiles)
    );

    bossRenderer renderer (
        .clk             (clk),
        .reset           (reset),
        .pixelX          (pixelX),
        .pixelY          (pixelY),
        .bossPos         (bossPos),
        .bossVisible     (bossVisible),
        .missiles        (missiles),
        .bossDrawReq     (bossDrawReq),
        .bossRGB         (bossRGB),
        .missileDrawReq  (missileDrawReq),
        .missileRGB      (missileRGB),
        .bossPixelHit    (bossPixelHit),
        .missilePixelHit (missilePixelHit)
    );

endmodule

// File: sim/bossObject_properties.sv
module bossObject_properties (
    input logic            clk,
    input logic            reset,
    input logic            bossDrawReq,
    input bossPkg::color_t bossRGB,
    input logic            missileDrawReq,
    input bossPkg::color_t missileRGB
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0; // Assertion failures so far.

    assert property (@(posedge clk) reset |=> !bossDrawReq && !missileDrawReq)
        else begin
            $error("Drawing request high in the cycle after reset");
            failCount++;
        end
    assert property (@(posedge clk) !bossDrawReq |-> bossRGB == '0)
        else begin
            $error("Boss colour not zero without a request");
            failCount++;
        end
    assert property (@(posedge clk) !missileDrawReq |-> missileRGB == '0)
        else begin
            $error("Missile colour not zero without a request");
            failCount++;
        end
    assert property (@(posedge clk) bossDrawReq |-> bossRGB == bossPkg::bossColor)
        else begin
            $error("Boss colour wrong with a request");
            failCount++;
        end
    assert property (@(posedge clk) missileDrawReq |-> missileRGB == bossPkg::missileColor)
        else begin
            $error("Missile colour wrong with a request");
            failCount++;
        end

endmodule

bind bossRenderer bossObject_properties rendererChecks (.*);
bind bossObject bossObject_properties topChecks (.*);

// File: sim/bossObjectTb.sv
module bossObjectTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clockPeriod = 20;
    localparam int testFrames = 850; // Frames of all tests together.
    localparam int frameCycles = 50; // Frame pulse plus the most probes in one frame.

    logic clk;
    logic reset;
    logic enable;
    logic startOfFrame;
    bossPkg::coord_t pixelX;
    bossPkg::coord_t pixelY;
    bossPkg::collision_t collision;
    logic bossDrawReq;
    bossPkg::color_t bossRGB;
    logic missileDrawReq;
    bossPkg::color_t missileRGB;

    int bossX, bossY, coolCount, deathTicks; // Reference model.
    bit goRight, goDown, phase, hitSeen, shown;
    int slotX[bossPkg::missileCount];
    int slotY[bossPkg::missileCount];
    int slotStep[bossPkg::missileCount];
    bit slotOn[bossPkg::missileCount];
    int errorCount = 0;
    int checkCount = 0;
    int testErrors = 0;

    bossObject dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clockPeriod / 2) clk = ~clk;
    end

    initial begin
        #(testFrames * frameCycles * clockPeriod + 200 * clockPeriod);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic resetDut();
        reset = 1'b1;
        repeat (3) nextCycle();
        reset = 1'b0;
        bossX = bossPkg::initialX;
        bossY = bossPkg::initialY;
        goRight = 1'b1;
        goDown = 1'b1;
        coolCount = 0;
        deathTicks = 0;
        phase = 1'b0;
        hitSeen = 1'b0;
        shown = 1'b1;
        foreach (slotOn[i]) slotOn[i] = 1'b0;
    endtask

    task automatic moveAxis(inout int pos, inout bit dir, input int step, input int lo,
                            input int hi);
        pos = pos + (dir ? step : -step);
        if (pos > hi || pos < lo) begin
            pos = (pos > hi) ? hi : lo; // Clamp and turn around.
            dir = !dir;
        end
    endtask

    task automatic modelTick();
        if (!hitSeen && coolCount == bossPkg::cooldownFrames - 1) begin
            for (int i = 0; i < bossPkg::missileCount; i++) begin
                slotOn[i] = 1'b1;
                slotX[i] = bossX + bossPkg::missileOffsetX;
                slotY[i] = bossY + bossPkg::missileOffsetY;
                slotStep[i] = i - 2;
            end
            coolCount = 0;
        end else begin
            coolCount = hitSeen ? coolCount : coolCount + 1;
            for (int i = 0; i < bossPkg::missileCount; i++) begin
                if (phase && slotOn[i]) begin // Missiles fall on every other tick.
                    slotX[i] += slotStep[i];
                    slotY[i] += bossPkg::missileStepY;
                    slotOn[i] = slotY[i] < bossPkg::screenHeight;
                end
            end
        end
        phase = !phase;
        if (hitSeen && shown) begin
            shown = deathTicks < bossPkg::deathFrames - 1;
            deathTicks++;
        end
        moveAxis(bossX, goRight, bossPkg::bossStepX, bossPkg::bossMinX, bossPkg::bossMaxX);
        moveAxis(bossY, goDown, bossPkg::bossStepY, bossPkg::bossMinY, bossPkg::bossMaxY);
    endtask

    task automatic runFrame(input logic en);
        startOfFrame = 1'b1;
        enable = en;
        nextCycle();
        startOfFrame = 1'b0;
        if (en)
            modelTick();
    endtask

    function automatic bossPkg::position_t posOf(input int x, input int y);
        bossPkg::position_t p;
        p.x = bossPkg::coord_t'(x);
        p.y = bossPkg::coord_t'(y);
        return p;
    endfunction

    function automatic logic bossExpected(input int px, input int py);
        int ox;
        int oy;
        ox = px - bossX;
        oy = py - bossY;
        if (!shown || ox < 0 || oy < 0 || ox >= bossPkg::bossSize || oy >= bossPkg::bossSize)
            return 1'b0;
        return bossPkg::bossMask[oy / 8][7 - ox / 8];
    endfunction

    function automatic logic covers(input int slot, input int px, input int py);
        return slotOn[slot] && px >= slotX[slot] && px < slotX[slot] + bossPkg::missileSize
            && py >= slotY[slot] && py < slotY[slot] + bossPkg::missileSize;
    endfunction

    function automatic logic missileExpected(input int px, input int py);
        logic any;
        any = 1'b0;
        for (int i = 0; i < bossPkg::missileCount; i++) begin
            any = any | covers(i, px, py);
        end
        return any;
    endfunction

    task automatic checkFlag(input string what, input logic got, input logic expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic checkColor(input string what, input bossPkg::color_t got,
                              input bossPkg::color_t expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // The answer to a pixel comes out one cycle after it is applied.
    task automatic probe(input int px, input int py);
        logic wantBoss;
        logic wantMissile;
        string where;
        wantBoss = bossExpected(px, py);
        wantMissile = missileExpected(px, py);
        where = $sformatf(" at pixel (%0d,%0d)", px, py);
        pixelX = bossPkg::coord_t'(px);
        pixelY = bossPkg::coord_t'(py);
        nextCycle();
        checkFlag({"boss request", where}, bossDrawReq, wantBoss);
        checkColor({"boss colour", where}, bossRGB, wantBoss ? bossPkg::bossColor : 8'h00);
        checkFlag({"missile request", where}, missileDrawReq, wantMissile);
        checkColor({"missile colour", where}, missileRGB,
                   wantMissile ? bossPkg::missileColor : 8'h00);
    endtask

    // Corners, then the pixels just past the bottom corners.
    task automatic checkPos(input bossPkg::position_t pos, input int size);
        int x;
        int y;
        x = pos.x;
        y = pos.y;
        probe(x, y);
        probe(x + size - 1, y);
        probe(x, y + size - 1);
        probe(x + size - 1, y + size - 1);
        probe(x - 1, y + size - 1);
        probe(x + size, y + size - 1);
        probe(x, y + size);
        probe(x + size - 1, y + size);
    endtask

    task automatic checkMissiles();
        for (int i = 0; i < bossPkg::missileCount; i++) begin
            checkPos(posOf(slotX[i], slotY[i]), bossPkg::missileSize);
        end
    endtask

    // Collision flags line up with the request of the pixel probed just before.
    task automatic strike(input int px, input int py, input bossPkg::collision_t flags);
        probe(px, py);
        collision = flags;
        nextCycle();
        collision = '0;
    endtask

    task automatic finishTest(input string name);
        $display("Test %s finished with %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    task automatic testReset();
        resetDut();
        checkFlag("boss request after reset", bossDrawReq, 1'b0);
        checkFlag("missile request after reset", missileDrawReq, 1'b0);
        probe(bossX + 28, bossY + 4); // Row 0, block 3 is set.
        checkFlag("boss request in a set block", bossDrawReq, 1'b1);
        checkColor("boss colour in a set block", bossRGB, bossPkg::bossColor);
        probe(bossX + 4, bossY + 4);
        checkFlag("boss request in a clear block", bossDrawReq, 1'b0);
        checkPos(posOf(bossX, bossY), bossPkg::bossSize);
        finishTest("reset and sprite mask");
    endtask

    task automatic testBounce();
        resetDut();
        for (int f = 1; f <= 200; f++) begin
            runFrame(1'b1);
            checkPos(posOf(bossX, bossY), bossPkg::bossSize);
            if (f % 10 == 0) begin
                runFrame(1'b0);
                checkPos(posOf(bossX, bossY), bossPkg::bossSize);
            end
        end
        finishTest("boss bounce");
    endtask

    task automatic testVolley();
        resetDut();
        repeat (89) runFrame(1'b1);
        probe(bossX + bossPkg::missileOffsetX + 1, bossY + bossPkg::missileOffsetY + 1);
        checkFlag("missile before the volley", missileDrawReq, 1'b0);
        runFrame(1'b1);
        probe(slotX[2] + 1, slotY[2] + 1);
        checkColor("missile colour at spawn", missileRGB, bossPkg::missileColor);
        checkMissiles();
        repeat (60) begin
            runFrame(1'b1);
            checkMissiles();
        end
        finishTest("missile volley");
    endtask

    task automatic testMissileStrike();
        int px;
        int py;
        resetDut();
        repeat (110) runFrame(1'b1); // Fan has spread apart by now.
        px = slotX[1] + 1;
        py = slotY[1] + 1;
        strike(px, py, 7'b0000100);
        for (int i = 0; i < bossPkg::missileCount; i++) begin
            if (covers(i, px, py))
                slotOn[i] = 1'b0;
        end
        probe(px, py);
        checkFlag("struck missile request", missileDrawReq, 1'b0);
        repeat (20) begin
            runFrame(1'b1);
            checkMissiles();
        end
        finishTest("missile strike");
    endtask

    task automatic testBossDeath();
        resetDut();
        repeat (100) runFrame(1'b1);
        strike(bossX + 4, bossY + 36, 7'b0000001); // Row 4 is solid.
        hitSeen = 1'b1;
        for (int f = 1; f <= 240; f++) begin
            runFrame(1'b1);
            if (f <= 12) begin
                probe(bossX + 4, bossY + 36);
                checkFlag("boss request after the hit", bossDrawReq, f < 10);
            end
            if (f % 10 == 0)
                checkMissiles();
        end
        probe(slotX[2], slotY[2]);
        checkFlag("missile request below the screen", missileDrawReq, 1'b0);
        finishTest("boss death");
    endtask

    initial begin
        reset = 1'b1;
        enable = 1'b0;
        startOfFrame = 1'b0;
        pixelX = '0;
        pixelY = '0;
        collision = '0;
        testReset();
        testBounce();
        testVolley();
        testMissileStrike();
        testBossDeath();
        errorCount += dut.topChecks.failCount + dut.renderer.rendererChecks.failCount;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: all.f
source/bossPkg.sv
source/bossMotion.sv
source/missilePool.sv
source/bossRenderer.sv
source/bossObject.sv
sim/bossObject_properties.sv
sim/bossObjectTb.sv

// File: Bender.yml
package:
  name: boss_object

sources:
  - source/bossPkg.sv
  - source/bossMotion.sv
  - source/missilePool.sv
  - source/bossRenderer.sv
  - source/bossObject.sv
  - target: test
    files:
      - sim/bossObject_properties.sv
      - sim/bossObjectTb.sv
